// ==== Makefile ====
# Verilator build and run for the memory subsystem testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= rta_mem_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/cmd_decoder.sv ====
// Command checker and router
// Reads and triangle writes issue in the command cycle, patch start a cycle later
`timescale 1ns/1ps
`default_nettype none

`include "rta_config.svh"

module cmd_decoder
  import rta_mem_pkg::*;
  import rta_cmd_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  cmd_t                     cmd,
  input  logic                     cmd_valid,
  input  logic                     loading,
  output logic                     busy,
  output logic                     cmd_err,
  output logic                     patch_start,
  output logic [`RTA_STACK_AW-1:0] patch_base,
  output stack_word_t              patch_seed,
  output logic                     stack_rd,
  output logic [`RTA_BANK_W-1:0]   stack_bank,
  output logic [`RTA_STACK_AW-1:0] stack_addr,
  output logic                     tri_wr,
  output logic                     tri_rd,
  output logic [`RTA_TRI_W-1:0]    tri_id,
  output logic [1:0]               tri_slot,
  output stack_word_t              tri_data
);

  logic                   in_range;
  logic                   accept;
  logic                   pending_start;
  logic [`RTA_ADDR_W-3:0] addr_id;

  // Triangle id sits above the slot bits
  assign addr_id = cmd.addr[`RTA_ADDR_W-1:2];

  // Range check per opcode, NOP never passes
  always_comb begin
    case (cmd.op)
      // Whole patch must fit without wrapping
      CMD_PATCH:    in_range = cmd.addr <= (`RTA_STACK_DEPTH - `RTA_PATCH_ROUNDS);
      CMD_STACK_RD: in_range = (cmd.bank < `RTA_NUM_BANK) && (cmd.addr < `RTA_STACK_DEPTH);
      CMD_TRI_WR,
      CMD_TRI_RD:   in_range = (addr_id < `RTA_NUM_TRI) && (cmd.addr[1:0] != 2'd3);
      default:      in_range = 1'b0;
    endcase
  end

  // Pending start covers the cycle before the loader reports loading
  assign busy   = pending_start | loading;
  assign accept = cmd_valid && !busy && in_range;

  // Strobes to exactly one target
  assign stack_rd = accept && (cmd.op == CMD_STACK_RD);
  assign tri_wr   = accept && (cmd.op == CMD_TRI_WR);
  assign tri_rd   = accept && (cmd.op == CMD_TRI_RD);

  assign stack_bank = cmd.bank[`RTA_BANK_W-1:0];
  assign stack_addr = cmd.addr[`RTA_STACK_AW-1:0];
  assign tri_id     = addr_id[`RTA_TRI_W-1:0];
  assign tri_slot   = cmd.addr[1:0];
  assign tri_data   = cmd.data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_start <= 1'b0;
      cmd_err       <= 1'b0;
    end else begin
      pending_start <= accept && (cmd.op == CMD_PATCH);
      // One-cycle error pulse for any rejected command
      cmd_err       <= cmd_valid && !accept;
    end
  end

  // Patch parameters held for the loader
  always_ff @(posedge clk) begin
    if (accept && (cmd.op == CMD_PATCH)) begin
      patch_base <= cmd.addr[`RTA_STACK_AW-1:0];
      patch_seed <= cmd.data;
    end
  end

  assign patch_start = pending_start;

endmodule

`default_nettype wire

// ==== logic/patch_loader.sv ====
// Test patch loader for the stack banks
// On start writes RTA_PATCH_ROUNDS rounds into every bank in parallel,
// round k puts seed+4k+b at base+k of bank b, then pulses patch_done
`timescale 1ns/1ps
`default_nettype none

`include "rta_config.svh"

module patch_loader
  import rta_mem_pkg::*;
  import rta_cmd_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 start,
  input  logic [`RTA_STACK_AW-1:0]             base,
  input  stack_word_t                          seed,
  output logic                                 loading,
  output logic                                 patch_done,
  output logic [`RTA_NUM_BANK-1:0]             wr_en,
  output logic [`RTA_STACK_AW-1:0]             wr_addr,
  output stack_word_t [`RTA_NUM_BANK-1:0]      wr_data
);

  localparam int CNT_W = $clog2(`RTA_PATCH_ROUNDS + 1);

  loader_state_t    state;
  loader_state_t    nxt_state;
  logic [CNT_W-1:0] cnt;
  logic             step;
  logic             last_round;

  // ==============================
  // FSM
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= LD_IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  assign last_round = (cnt == CNT_W'(`RTA_PATCH_ROUNDS));

  always_comb begin
    nxt_state  = state;
    step       = 1'b0;
    patch_done = 1'b0;
    case (state)
      LD_IDLE: begin
        if (start) begin
          nxt_state = LD_LOAD;
        end
      end
      LD_LOAD: begin
        // Extra cycle after the last write signals completion
        if (last_round) begin
          patch_done = 1'b1;
          nxt_state  = LD_IDLE;
        end else begin
          step = 1'b1;
        end
      end
      default: nxt_state = LD_IDLE;
    endcase
  end

  assign loading = (state == LD_LOAD);
  // All banks written together
  assign wr_en   = {`RTA_NUM_BANK{step}};

  // Round counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (start) begin
      cnt <= '0;
    end else if (step) begin
      cnt <= cnt + 1'b1;
    end
  end

  // ==============================
  // Address and data
  // ==============================
  always_ff @(posedge clk) begin
    if (start) begin
      wr_addr <= base;
      for (int b = 0; b < `RTA_NUM_BANK; b++) begin
        wr_data[b] <= seed + stack_word_t'(b);
      end
    end else if (step) begin
      wr_addr <= wr_addr + 1'b1;
      // Step by bank count keeps banks interleaved
      for (int b = 0; b < `RTA_NUM_BANK; b++) begin
        wr_data[b] <= wr_data[b] + stack_word_t'(`RTA_NUM_BANK);
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/resp_merge.sv ====
// Response merger for the stack and triangle read paths
// Stack wins a collision; the losing triangle waits in a one-entry hold
// and goes out before any newer triangle result
`timescale 1ns/1ps
`default_nettype none

module resp_merge
  import rta_mem_pkg::*;
  import rta_cmd_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        stack_valid,
  input  stack_word_t stack_word,
  input  logic        tri_valid,
  input  triangle_t   tri_result,
  output resp_t       resp,
  output logic        resp_valid
);

  logic      hold_valid;
  triangle_t hold_tri;

  // ==============================
  // Control
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      resp_valid <= stack_valid | hold_valid | tri_valid;
      if (stack_valid) begin
        // Collision parks the triangle
        if (tri_valid) begin
          hold_valid <= 1'b1;
        end
      end else if (hold_valid) begin
        // Held entry drains, a new triangle takes its place
        hold_valid <= tri_valid;
      end
    end
  end

  // ==============================
  // Payload
  // ==============================
  // One command per cycle keeps a second collision off a full hold
  always_ff @(posedge clk) begin
    if (stack_valid) begin
      resp.src      <= SRC_STACK;
      resp.word     <= stack_word;
      resp.triangle <= '0;
      if (tri_valid) begin
        hold_tri <= tri_result;
      end
    end else if (hold_valid) begin
      resp.src      <= SRC_TRI;
      resp.word     <= '0;
      resp.triangle <= hold_tri;
      hold_tri      <= tri_result;
    end else if (tri_valid) begin
      resp.src      <= SRC_TRI;
      resp.word     <= '0;
      resp.triangle <= tri_result;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rta_cmd_pkg.sv ====
// Command, response and control state types of the memory subsystem
// Import into the decoder, loader, merger and top level
`default_nettype none

`include "rta_config.svh"

package rta_cmd_pkg;

  import rta_mem_pkg::*;

  // Command opcodes
  typedef enum logic [2:0] {
    CMD_NOP,
    CMD_PATCH,
    CMD_TRI_WR,
    CMD_STACK_RD,
    CMD_TRI_RD
  } cmd_op_t;

  // Triangle ops use addr as {id, slot[1:0]}
  typedef struct packed {
    cmd_op_t                   op;
    logic [`RTA_CMD_BANK_W-1:0] bank;
    logic [`RTA_ADDR_W-1:0]    addr;
    stack_word_t               data;
  } cmd_t;

  // Which read path a response came from
  typedef enum logic {
    SRC_STACK,
    SRC_TRI
  } resp_src_t;

  // Unused half of a response is zero
  typedef struct packed {
    resp_src_t   src;
    stack_word_t word;
    triangle_t   triangle;
  } resp_t;

  // Patch loader FSM
  typedef enum logic {
    LD_IDLE,
    LD_LOAD
  } loader_state_t;

endpackage

`default_nettype wire

// ==== logic/rta_config.svh ====
// Sizing for the accelerator memory subsystem
// Include wherever bank count, depths or widths are needed
`ifndef RTA_CONFIG_SVH
`define RTA_CONFIG_SVH

// ==============================
// Stack memory
// ==============================
// One stack bank per RT core
`define RTA_NUM_BANK      4
`define RTA_STACK_DEPTH   256
`define RTA_WORD_W        128
`define RTA_BANK_W        ($clog2(`RTA_NUM_BANK))
`define RTA_STACK_AW      ($clog2(`RTA_STACK_DEPTH))
// Write rounds in one test patch load
`define RTA_PATCH_ROUNDS  8

// ==============================
// Triangle memory and commands
// ==============================
`define RTA_NUM_TRI       64
`define RTA_TRI_W         ($clog2(`RTA_NUM_TRI))
`define RTA_COORD_W       32
// Command fields, wider than needed so bad values can be flagged
`define RTA_ADDR_W        16
`define RTA_CMD_BANK_W    4

`endif

// ==== logic/rta_mem_pkg.sv ====
// Data types held in the stack and triangle memories
// Import into any block that stores or moves memory words
`default_nettype none

`include "rta_config.svh"

package rta_mem_pkg;

  // One stack memory word
  typedef logic [`RTA_WORD_W-1:0] stack_word_t;

  // Single vertex, x in the top bits
  typedef struct packed {
    logic [`RTA_COORD_W-1:0] x;
    logic [`RTA_COORD_W-1:0] y;
    logic [`RTA_COORD_W-1:0] z;
  } vertex_t;

  // Full triangle as seen by an IC core
  // not_valid set means vertices and sid read as zero
  typedef struct packed {
    vertex_t v0;
    vertex_t v1;
    vertex_t v2;
    logic    sid;
    logic    not_valid;
  } triangle_t;

endpackage

`default_nettype wire

// ==== logic/rta_mem_top.sv ====
// Memory side of the ray-tracing accelerator
// Command port feeds the stack and triangle paths, one merged response stream
`timescale 1ns/1ps
`default_nettype none

`include "rta_config.svh"

module rta_mem_top
  import rta_mem_pkg::*;
  import rta_cmd_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd,
  input  logic  cmd_valid,
  output resp_t resp,
  output logic  resp_valid,
  output logic  cmd_err,
  output logic  busy,
  output logic  patch_done
);

  // Decoder to loader
  logic                            loading;
  logic                            patch_start;
  logic [`RTA_STACK_AW-1:0]        patch_base;
  stack_word_t                     patch_seed;
  // Decoder to memories
  logic                            stack_rd;
  logic [`RTA_BANK_W-1:0]          stack_bank;
  logic [`RTA_STACK_AW-1:0]        stack_addr;
  logic                            tri_wr;
  logic                            tri_rd;
  logic [`RTA_TRI_W-1:0]           tri_id;
  logic [1:0]                      tri_slot;
  stack_word_t                     tri_data;
  // Loader to stack memory
  logic [`RTA_NUM_BANK-1:0]        ld_wr_en;
  logic [`RTA_STACK_AW-1:0]        ld_wr_addr;
  stack_word_t [`RTA_NUM_BANK-1:0] ld_wr_data;
  // Read results into the merger
  stack_word_t                     stack_rd_data;
  logic                            stack_rd_valid;
  triangle_t                       tri_rd_tri;
  logic                            tri_rd_valid;

  cmd_decoder u_cmd_decoder (
    .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_valid(cmd_valid),
    .loading(loading), .busy(busy), .cmd_err(cmd_err),
    .patch_start(patch_start), .patch_base(patch_base), .patch_seed(patch_seed),
    .stack_rd(stack_rd), .stack_bank(stack_bank), .stack_addr(stack_addr),
    .tri_wr(tri_wr), .tri_rd(tri_rd), .tri_id(tri_id),
    .tri_slot(tri_slot), .tri_data(tri_data)
  );

  patch_loader u_patch_loader (
    .clk(clk), .rst_n(rst_n), .start(patch_start), .base(patch_base),
    .seed(patch_seed), .loading(loading), .patch_done(patch_done),
    .wr_en(ld_wr_en), .wr_addr(ld_wr_addr), .wr_data(ld_wr_data)
  );

  stack_mem u_stack_mem (
    .clk(clk), .rst_n(rst_n), .wr_en(ld_wr_en), .wr_addr(ld_wr_addr),
    .wr_data(ld_wr_data), .rd_en(stack_rd), .rd_bank(stack_bank),
    .rd_addr(stack_addr), .rd_data(stack_rd_data), .rd_valid(stack_rd_valid)
  );

  // Same id field serves writes and reads
  tri_mem u_tri_mem (
    .clk(clk), .rst_n(rst_n), .wr_en(tri_wr), .wr_id(tri_id),
    .wr_slot(tri_slot), .wr_data(tri_data), .rd_en(tri_rd), .rd_id(tri_id),
    .rd_tri(tri_rd_tri), .rd_valid(tri_rd_valid)
  );

  resp_merge u_resp_merge (
    .clk(clk), .rst_n(rst_n), .stack_valid(stack_rd_valid),
    .stack_word(stack_rd_data), .tri_valid(tri_rd_valid),
    .tri_result(tri_rd_tri), .resp(resp), .resp_valid(resp_valid)
  );

endmodule

`default_nettype wire

// ==== logic/stack_mem.sv ====
// Banked stack memory, one bank per RT core
// Banks take parallel writes; a read picks one bank, data one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "rta_config.svh"

module stack_mem
  import rta_mem_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [`RTA_NUM_BANK-1:0]        wr_en,
  input  logic [`RTA_STACK_AW-1:0]        wr_addr,
  input  stack_word_t [`RTA_NUM_BANK-1:0] wr_data,
  input  logic                            rd_en,
  input  logic [`RTA_BANK_W-1:0]          rd_bank,
  input  logic [`RTA_STACK_AW-1:0]        rd_addr,
  output stack_word_t                     rd_data,
  output logic                            rd_valid
);

  // Raw word at rd_addr from each bank
  stack_word_t [`RTA_NUM_BANK-1:0] bank_rd;

  // ==============================
  // Bank arrays
  // ==============================
  for (genvar b = 0; b < `RTA_NUM_BANK; b++) begin : g_bank
    stack_word_t bank_q [`RTA_STACK_DEPTH];

    always_ff @(posedge clk) begin
      if (wr_en[b]) begin
        bank_q[wr_addr] <= wr_data[b];
      end
    end

    assign bank_rd[b] = bank_q[rd_addr];
  end

  // Read port
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= bank_rd[rd_bank];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

endmodule

`default_nettype wire

// ==== logic/tri_mem.sv ====
// Triangle memory, written one vertex slot at a time
// Slot 0 also stores the shader id and invalidates the triangle,
// slot 2 validates it; a read takes two cycles
`timescale 1ns/1ps
`default_nettype none

`include "rta_config.svh"

module tri_mem
  import rta_mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  logic [`RTA_TRI_W-1:0] wr_id,
  input  logic [1:0]            wr_slot,
  input  stack_word_t           wr_data,
  input  logic                  rd_en,
  input  logic [`RTA_TRI_W-1:0] rd_id,
  output triangle_t             rd_tri,
  output logic                  rd_valid
);

  vertex_t                 vtx0_q [`RTA_NUM_TRI];
  vertex_t                 vtx1_q [`RTA_NUM_TRI];
  vertex_t                 vtx2_q [`RTA_NUM_TRI];
  logic                    sid_q  [`RTA_NUM_TRI];
  logic [`RTA_NUM_TRI-1:0] valid_q;

  // Stage one raw entries
  vertex_t   s1_v0;
  vertex_t   s1_v1;
  vertex_t   s1_v2;
  logic      s1_sid;
  logic      s1_valid;
  logic      s1_en;
  triangle_t tri_asm;

  // ==============================
  // Write side
  // ==============================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (wr_slot)
        2'd0: begin
          vtx0_q[wr_id] <= vertex_t'(wr_data[95:0]);
          sid_q[wr_id]  <= wr_data[96];
        end
        2'd1:    vtx1_q[wr_id] <= vertex_t'(wr_data[95:0]);
        default: vtx2_q[wr_id] <= vertex_t'(wr_data[95:0]);
      endcase
    end
  end

  // Valid bitmap, all triangles invalid out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (wr_en) begin
      if (wr_slot == 2'd0) begin
        valid_q[wr_id] <= 1'b0;
      end else if (wr_slot == 2'd2) begin
        valid_q[wr_id] <= 1'b1;
      end
    end
  end

  // ==============================
  // Read pipeline
  // ==============================
  always_ff @(posedge clk) begin
    if (rd_en) begin
      s1_v0    <= vtx0_q[rd_id];
      s1_v1    <= vtx1_q[rd_id];
      s1_v2    <= vtx2_q[rd_id];
      s1_sid   <= sid_q[rd_id];
      s1_valid <= valid_q[rd_id];
    end
  end

  // Invalid triangles come back zeroed
  always_comb begin
    tri_asm           = '0;
    tri_asm.not_valid = !s1_valid;
    if (s1_valid) begin
      tri_asm.v0  = s1_v0;
      tri_asm.v1  = s1_v1;
      tri_asm.v2  = s1_v2;
      tri_asm.sid = s1_sid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_en) begin
      rd_tri <= tri_asm;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_en    <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      s1_en    <= rd_en;
      rd_valid <= s1_en;
    end
  end

endmodule

`default_nettype wire

// ==== sim/rta_mem_assert.sv ====
// Concurrent checks on the memory subsystem top level
// Bound into rta_mem_top, failures surface as assertion errors
`timescale 1ns/1ps
`default_nettype none

`include "rta_config.svh"

module rta_mem_assert (
  input logic clk,
  input logic rst_n,
  input logic resp_valid,
  input logic cmd_err,
  input logic busy,
  input logic patch_done
);

  // Registered outputs stay quiet during reset
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !resp_valid && !cmd_err && !patch_done)
    else $error("output strobe active during reset");

  // Done only inside the busy window
  a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
    patch_done |-> busy)
    else $error("patch_done outside busy window");

  // ==============================
  // Patch load length
  // ==============================
  a_done_after_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(busy) |-> ##(`RTA_PATCH_ROUNDS + 1) patch_done)
    else $error("patch_done missing after busy rose");

  // Not earlier either, busy rose exactly rounds+1 cycles back
  a_done_exact: assert property (@(posedge clk) disable iff (!rst_n)
    patch_done |-> $past(busy, `RTA_PATCH_ROUNDS + 1) && !$past(busy, `RTA_PATCH_ROUNDS + 2))
    else $error("patch_done at wrong distance from busy rise");

endmodule

bind rta_mem_top rta_mem_assert rta_mem_assert_inst (
  .clk(clk), .rst_n(rst_n), .resp_valid(resp_valid),
  .cmd_err(cmd_err), .busy(busy), .patch_done(patch_done)
);

`default_nettype wire

// ==== sim/rta_mem_tb.sv ====
// Testbench for the accelerator memory subsystem
// Runs patch load, command rejection, triangle, mixed read and repatch tests
// against a shadow model; responses are checked per source in order
`timescale 1ns/1ps
`default_nettype none

`include "rta_config.svh"

module rta_mem_tb
  import rta_mem_pkg::*;
  import rta_cmd_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int N_TRI_TEST   = 12;
  localparam int N_MIX        = 48;
  localparam int PATCH_CYCLES = `RTA_PATCH_ROUNDS + 4;
  localparam int DRAIN_CYCLES = 8;
  // Summed test lengths, doubled for margin
  localparam int CYCLE_LIMIT  = 2 * (3 * PATCH_CYCLES + 5 * DRAIN_CYCLES +
                                     3 * `RTA_NUM_BANK * `RTA_PATCH_ROUNDS +
                                     6 * N_TRI_TEST + N_MIX + 40);

  logic  clk;
  logic  rst_n;
  cmd_t  cmd;
  logic  cmd_valid;
  resp_t resp;
  logic  resp_valid;
  logic  cmd_err;
  logic  busy;
  logic  patch_done;

  // Shadow model
  stack_word_t stack_ref [`RTA_NUM_BANK][`RTA_STACK_DEPTH];
  vertex_t     tri_v0 [`RTA_NUM_TRI];
  vertex_t     tri_v1 [`RTA_NUM_TRI];
  vertex_t     tri_v2 [`RTA_NUM_TRI];
  logic        tri_sid [`RTA_NUM_TRI];
  logic        tri_ok [`RTA_NUM_TRI];
  // Expected responses, one queue per source
  stack_word_t exp_stack_q [$];
  triangle_t   exp_tri_q [$];

  logic [31:0] lcg_state;
  int          errors;
  int          exp_err;
  int          err_seen;
  int          exp_done;
  int          done_seen;
  int          cycles;
  int          tests_run;
  int          tests_failed;
  int          test_err_base;

  rta_mem_top rta_mem_top_inst (
    .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_valid(cmd_valid),
    .resp(resp), .resp_valid(resp_valid), .cmd_err(cmd_err),
    .busy(busy), .patch_done(patch_done)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  // ==============================
  // Reference model
  // ==============================
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic stack_word_t rand_word();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  // Round k of bank b holds seed+4k+b
  function automatic stack_word_t patch_word(stack_word_t seed, int k, int b);
    return seed + stack_word_t'(4 * k + b);
  endfunction

  // Invalid triangle reads as not_valid with zero payload
  function automatic triangle_t expected_triangle(int id);
    triangle_t t;
    t           = '0;
    t.not_valid = !tri_ok[id];
    if (tri_ok[id]) begin
      t.v0  = tri_v0[id];
      t.v1  = tri_v1[id];
      t.v2  = tri_v2[id];
      t.sid = tri_sid[id];
    end
    return t;
  endfunction

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_stack_word(string name, stack_word_t got, stack_word_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_triangle(string name, triangle_t got, triangle_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  // ==============================
  // Stimulus
  // ==============================
  task automatic send_cmd(cmd_op_t op, int bank, int addr, stack_word_t data);
    @(posedge clk);
    #1;
    cmd.op    = op;
    cmd.bank  = 4'(bank);
    cmd.addr  = 16'(addr);
    cmd.data  = data;
    cmd_valid = 1'b1;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    cmd       = '0;
  endtask

  task automatic issue_patch(int base, stack_word_t seed);
    send_cmd(CMD_PATCH, 0, base, seed);
    exp_done++;
    for (int b = 0; b < `RTA_NUM_BANK; b++) begin
      for (int k = 0; k < `RTA_PATCH_ROUNDS; k++) begin
        stack_ref[b][base + k] = patch_word(seed, k, b);
      end
    end
  endtask

  task automatic issue_stack_rd(int bank, int addr);
    send_cmd(CMD_STACK_RD, bank, addr, '0);
    exp_stack_q.push_back(stack_ref[bank][addr]);
  endtask

  // Slot 0 invalidates and sets sid, slot 2 validates
  task automatic issue_tri_wr(int id, int slot, stack_word_t data);
    send_cmd(CMD_TRI_WR, 0, (id << 2) | slot, data);
    case (slot)
      0: begin
        tri_v0[id]  = vertex_t'(data[95:0]);
        tri_sid[id] = data[96];
        tri_ok[id]  = 1'b0;
      end
      1: tri_v1[id] = vertex_t'(data[95:0]);
      default: begin
        tri_v2[id] = vertex_t'(data[95:0]);
        tri_ok[id] = 1'b1;
      end
    endcase
  endtask

  task automatic issue_tri_rd(int id);
    send_cmd(CMD_TRI_RD, 0, id << 2, '0);
    exp_tri_q.push_back(expected_triangle(id));
  endtask

  // Command that must be rejected with a cmd_err pulse
  task automatic issue_bad(cmd_op_t op, int bank, int addr);
    send_cmd(op, bank, addr, rand_word());
    exp_err++;
  endtask

  task automatic wait_not_busy();
    drive_idle();
    do begin
      @(negedge clk);
    end while (busy);
  endtask

  // Extra cycles catch late strays and error pulses
  task automatic wait_drain();
    drive_idle();
    while (exp_stack_q.size() != 0 || exp_tri_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (DRAIN_CYCLES) @(negedge clk);
    #1;
  endtask

  task automatic end_test(string name);
    check_count("cmd_err pulses", err_seen, exp_err);
    check_count("patch_done pulses", done_seen, exp_done);
    tests_run++;
    if (errors != test_err_base) begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, errors - test_err_base);
    end else begin
      $display("Test %0d %s: ok", tests_run, name);
    end
    test_err_base = errors;
  endtask

  // ==============================
  // Response compare and monitors
  // ==============================
  always @(negedge clk) begin
    if (rst_n && cmd_err) begin
      err_seen++;
    end
    if (rst_n && patch_done) begin
      done_seen++;
    end
    if (rst_n && resp_valid) begin
      if (resp.src == SRC_STACK) begin
        if (exp_stack_q.size() == 0) begin
          errors++;
          $display("Unexpected stack response at %0t with no read outstanding", $time);
        end else begin
          check_stack_word("resp.word", resp.word, exp_stack_q.pop_front());
        end
      end else begin
        if (exp_tri_q.size() == 0) begin
          errors++;
          $display("Unexpected triangle response at %0t with no read outstanding", $time);
        end else begin
          check_triangle("resp.triangle", resp.triangle, exp_tri_q.pop_front());
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    int base1;
    int base2;
    int kind;
    lcg_state     = 32'd36703;
    errors        = 0;
    exp_err       = 0;
    err_seen      = 0;
    exp_done      = 0;
    done_seen     = 0;
    cycles        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err_base = 0;
    rst_n         = 1'b0;
    cmd           = '0;
    cmd_valid     = 1'b0;
    for (int i = 0; i < `RTA_NUM_TRI; i++) begin
      tri_ok[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Patch load, then every written word in every bank
    base1 = int'(next_rand() % 32'd241);
    issue_patch(base1, rand_word());
    wait_not_busy();
    for (int b = 0; b < `RTA_NUM_BANK; b++) begin
      for (int k = 0; k < `RTA_PATCH_ROUNDS; k++) begin
        issue_stack_rd(b, base1 + k);
      end
    end
    wait_drain();
    end_test("patch load readback");

    // Commands during busy, then out of range fields
    issue_patch(base1, rand_word());
    issue_bad(CMD_STACK_RD, 0, base1);
    issue_bad(CMD_TRI_WR, 0, 2);
    issue_bad(CMD_TRI_RD, 0, 4);
    wait_not_busy();
    issue_bad(CMD_STACK_RD, 4, base1);
    issue_bad(CMD_STACK_RD, 0, `RTA_STACK_DEPTH);
    issue_bad(CMD_PATCH, 0, `RTA_STACK_DEPTH - `RTA_PATCH_ROUNDS + 1);
    issue_bad(CMD_TRI_WR, 0, (1 << 2) | 3);
    issue_bad(CMD_TRI_RD, 0, `RTA_NUM_TRI << 2);
    issue_bad(CMD_NOP, 0, 0);
    issue_tri_rd(0);
    issue_tri_rd(1);
    for (int b = 0; b < `RTA_NUM_BANK; b++) begin
      issue_stack_rd(b, base1);
    end
    wait_drain();
    end_test("rejected commands");

    // Complete, partial and invalidated triangles
    for (int i = 0; i < N_TRI_TEST; i++) begin
      kind = int'(next_rand() % 32'd3);
      issue_tri_wr(i + 2, 0, rand_word());
      issue_tri_wr(i + 2, 1, rand_word());
      if (kind != 1) begin
        issue_tri_wr(i + 2, 2, rand_word());
      end
      if (kind == 2) begin
        issue_tri_wr(i + 2, 0, rand_word());
      end
    end
    for (int id = 0; id < N_TRI_TEST + 4; id++) begin
      issue_tri_rd(id);
    end
    wait_drain();
    end_test("triangle write and read");

    // Back to back mix, tri then stack collides in the merger
    for (int i = 0; i < N_MIX; i++) begin
      if (next_rand() % 32'd2 == 0) begin
        issue_stack_rd(int'(next_rand() % 32'd4), base1 + int'(next_rand() % 32'd8));
      end else begin
        issue_tri_rd(int'(next_rand() % (N_TRI_TEST + 4)));
      end
    end
    wait_drain();
    end_test("interleaved reads");

    // Overlapping repatch, triangles untouched
    base2 = base1 + 1 + int'(next_rand() % 32'd6);
    issue_patch(base2, rand_word());
    wait_not_busy();
    for (int b = 0; b < `RTA_NUM_BANK; b++) begin
      for (int a = base1; a < base2 + `RTA_PATCH_ROUNDS; a++) begin
        issue_stack_rd(b, a);
      end
    end
    for (int id = 0; id < N_TRI_TEST + 4; id++) begin
      issue_tri_rd(id);
    end
    wait_drain();
    end_test("overlapping repatch");

    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+logic
logic/rta_mem_pkg.sv
logic/rta_cmd_pkg.sv
logic/cmd_decoder.sv
logic/patch_loader.sv
logic/stack_mem.sv
logic/tri_mem.sv
logic/resp_merge.sv
logic/rta_mem_top.sv
sim/rta_mem_assert.sv
sim/rta_mem_tb.sv
